//--- rtl/ccm_mem_params.svh
//*********************************************************************
// Size and address field constants for the DCCM and ICCM banks
// Included by the package and by every module that slices addresses
//*********************************************************************

`ifndef CCM_MEM_PARAMS_SVH
`define CCM_MEM_PARAMS_SVH

// Byte address widths, 1 KB each
`define DCCM_BITS        10
`define ICCM_BITS        10

// Bank organisation shared by both memories
`define CCM_NUM_BANKS    4
`define CCM_BANK_BITS    2

// Byte offset inside one bank word
`define CCM_WIDTH_BITS   2
`define CCM_DATA_WIDTH   32

// Row index inside a bank
// Address bits above the bank select
`define CCM_INDEX_BITS   6

`endif

//--- rtl/ccm_mem_pkg.sv
//*********************************************************************
// Request, response and per-bank command types for the CCM block
// Imported by the decoders, the banks and the read-return stages
//*********************************************************************

`include "ccm_mem_params.svh"

package ccm_mem_pkg;

   // DCCM side, lo/hi pair for misaligned accesses
   typedef struct packed {
      logic                        wren;
      logic                        rden;
      logic [`DCCM_BITS-1:0]       wr_addr_lo;
      logic [`DCCM_BITS-1:0]       wr_addr_hi;
      logic [`DCCM_BITS-1:0]       rd_addr_lo;
      logic [`DCCM_BITS-1:0]       rd_addr_hi;
      logic [`CCM_DATA_WIDTH-1:0]  wr_data_lo;
      logic [`CCM_DATA_WIDTH-1:0]  wr_data_hi;
   } dccm_req_t;

   typedef struct packed {
      logic [`CCM_DATA_WIDTH-1:0]  rd_data_lo;
      logic [`CCM_DATA_WIDTH-1:0]  rd_data_hi;
   } dccm_rsp_t;

   // ICCM side, word address and 64-bit data
   typedef struct packed {
      logic                        wren;
      logic                        rden;
      logic [`ICCM_BITS-1:2]       rw_addr;
      logic [2:0]                  wr_size;   // 2 word, 3 double word
      logic [63:0]                 wr_data;
   } iccm_req_t;

   typedef struct packed {
      logic [63:0]                 rd_data;
   } iccm_rsp_t;

   // One SRAM bank access
   typedef struct packed {
      logic                        wren;
      logic                        rden;
      logic [`CCM_INDEX_BITS-1:0]  index;
      logic [`CCM_DATA_WIDTH-1:0]  wr_data;
   } bank_cmd_t;

   typedef bank_cmd_t [`CCM_NUM_BANKS-1:0] bank_cmd_vec_t;
   typedef logic [`CCM_NUM_BANKS-1:0][`CCM_DATA_WIDTH-1:0] bank_data_vec_t;

endpackage

//--- rtl/ccm_bank.sv
//*********************************************************************
// Single-port SRAM bank, one 32-bit word per row
// Write on wren, registered read on rden, read data held until next read
//*********************************************************************

`timescale 1ns/1ps
`include "ccm_mem_params.svh"

module ccm_bank
   import ccm_mem_pkg::*;
#(
   parameter int DEPTH = 64
)(
   input  logic                        clk,
   input  logic                        rst_n,
   input  bank_cmd_t                   cmd,
   output logic [`CCM_DATA_WIDTH-1:0]  rd_data
);

   localparam int ROW_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [`CCM_DATA_WIDTH-1:0]  mem [DEPTH];
   logic [ROW_BITS-1:0]         row;

   assign row = cmd.index[ROW_BITS-1:0];

   always_ff @(posedge clk) begin
      if (cmd.wren) mem[row] <= cmd.wr_data;
   end

   // Same-row write in this cycle is not yet visible
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) rd_data <= '0;
      else if (cmd.rden) rd_data <= mem[row];
   end

endmodule

//--- rtl/dccm_bank_decode.sv
//*********************************************************************
// DCCM bank decode, splits the lo/hi request into per-bank commands
// Purely combinational, feeds the four DCCM banks directly
//*********************************************************************

`timescale 1ns/1ps
`include "ccm_mem_params.svh"

module dccm_bank_decode
   import ccm_mem_pkg::*;
(
   input  dccm_req_t                   req,
   output bank_cmd_vec_t               bank_cmd,
   output logic [`CCM_BANK_BITS-1:0]   rd_bank_lo,
   output logic [`CCM_BANK_BITS-1:0]   rd_bank_hi
);

   localparam int BANK_LO  = `CCM_WIDTH_BITS;
   localparam int INDEX_LO = `CCM_WIDTH_BITS + `CCM_BANK_BITS;

   logic [`CCM_BANK_BITS-1:0]   wr_bank_lo;
   logic [`CCM_BANK_BITS-1:0]   wr_bank_hi;
   logic [`CCM_INDEX_BITS-1:0]  wr_index_lo;
   logic [`CCM_INDEX_BITS-1:0]  wr_index_hi;
   logic [`CCM_INDEX_BITS-1:0]  rd_index_lo;
   logic [`CCM_INDEX_BITS-1:0]  rd_index_hi;

   // Address split, bank in 3:2 and row above it
   assign wr_bank_lo  = req.wr_addr_lo[BANK_LO +: `CCM_BANK_BITS];
   assign wr_bank_hi  = req.wr_addr_hi[BANK_LO +: `CCM_BANK_BITS];
   assign rd_bank_lo  = req.rd_addr_lo[BANK_LO +: `CCM_BANK_BITS];
   assign rd_bank_hi  = req.rd_addr_hi[BANK_LO +: `CCM_BANK_BITS];   // Equals lo on a same-bank read
   assign wr_index_lo = req.wr_addr_lo[`DCCM_BITS-1:INDEX_LO];
   assign wr_index_hi = req.wr_addr_hi[`DCCM_BITS-1:INDEX_LO];
   assign rd_index_lo = req.rd_addr_lo[`DCCM_BITS-1:INDEX_LO];
   assign rd_index_hi = req.rd_addr_hi[`DCCM_BITS-1:INDEX_LO];

   always_comb begin
      bank_cmd = '0;
      for (int b = 0; b < `CCM_NUM_BANKS; b++) begin
         // Reads, lo takes the bank when both hit it
         if (req.rden && rd_bank_lo == `CCM_BANK_BITS'(b)) begin
            bank_cmd[b].rden  = 1'b1;
            bank_cmd[b].index = rd_index_lo;
         end else if (req.rden && rd_bank_hi == `CCM_BANK_BITS'(b)) begin
            bank_cmd[b].rden  = 1'b1;
            bank_cmd[b].index = rd_index_hi;
         end
         // Writes override the row, hi only in a bank of its own
         if (req.wren && wr_bank_lo == `CCM_BANK_BITS'(b)) begin
            bank_cmd[b].wren    = 1'b1;
            bank_cmd[b].index   = wr_index_lo;
            bank_cmd[b].wr_data = req.wr_data_lo;
         end else if (req.wren && wr_bank_hi == `CCM_BANK_BITS'(b)) begin
            bank_cmd[b].wren    = 1'b1;
            bank_cmd[b].index   = wr_index_hi;
            bank_cmd[b].wr_data = req.wr_data_hi;
         end
      end
   end

endmodule

//--- rtl/iccm_bank_decode.sv
//*********************************************************************
// ICCM bank decode, maps a word address onto two consecutive banks
// Reads and double writes use both, word writes only the start bank
//*********************************************************************

`timescale 1ns/1ps
`include "ccm_mem_params.svh"

module iccm_bank_decode
   import ccm_mem_pkg::*;
(
   input  iccm_req_t                   req,
   output bank_cmd_vec_t               bank_cmd,
   output logic [`CCM_BANK_BITS-1:0]   start_bank
);

   localparam int BANK_LO  = `CCM_WIDTH_BITS;
   localparam int INDEX_LO = `CCM_WIDTH_BITS + `CCM_BANK_BITS;

   logic [`CCM_BANK_BITS-1:0]   next_bank;
   logic [`CCM_INDEX_BITS-1:0]  start_index;
   logic [`CCM_INDEX_BITS-1:0]  next_index;
   logic                        dbl_write;

   assign start_bank  = req.rw_addr[BANK_LO +: `CCM_BANK_BITS];
   assign start_index = req.rw_addr[`ICCM_BITS-1:INDEX_LO];
   assign next_bank   = start_bank + `CCM_BANK_BITS'(1);   // Wraps 3 -> 0

   // Second word sits in the following row once the bank wraps
   assign next_index  = (next_bank == '0) ? start_index + `CCM_INDEX_BITS'(1)
                                          : start_index;

   assign dbl_write   = req.wren && (req.wr_size == 3'd3);

   always_comb begin
      bank_cmd = '0;
      for (int b = 0; b < `CCM_NUM_BANKS; b++) begin
         if (start_bank == `CCM_BANK_BITS'(b)) begin
            // Low word
            bank_cmd[b].wren    = req.wren;
            bank_cmd[b].rden    = req.rden;
            bank_cmd[b].index   = start_index;
            bank_cmd[b].wr_data = req.wr_data[31:0];
         end else if (next_bank == `CCM_BANK_BITS'(b)) begin
            // High word
            bank_cmd[b].wren    = dbl_write;
            bank_cmd[b].rden    = req.rden;
            bank_cmd[b].index   = next_index;
            bank_cmd[b].wr_data = req.wr_data[63:32];
         end
      end
   end

endmodule

//--- rtl/dccm_rd_return.sv
//*********************************************************************
// DCCM read return, steers bank read registers to the lo/hi outputs
// Bank selects are captured with rden and used the following cycle
//*********************************************************************

`timescale 1ns/1ps
`include "ccm_mem_params.svh"

module dccm_rd_return
   import ccm_mem_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        rden,
   input  logic [`CCM_BANK_BITS-1:0]   rd_bank_lo,
   input  logic [`CCM_BANK_BITS-1:0]   rd_bank_hi,
   input  bank_data_vec_t              bank_data,
   output dccm_rsp_t                   rsp
);

   logic [`CCM_BANK_BITS-1:0]  sel_lo_q;
   logic [`CCM_BANK_BITS-1:0]  sel_hi_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sel_lo_q <= '0;
         sel_hi_q <= '0;
      end else if (rden) begin
         sel_lo_q <= rd_bank_lo;
         sel_hi_q <= rd_bank_hi;
      end
   end

   // Output mux after the bank registers
   assign rsp.rd_data_lo = bank_data[sel_lo_q];
   assign rsp.rd_data_hi = bank_data[sel_hi_q];

endmodule

//--- rtl/iccm_rd_return.sv
//*********************************************************************
// ICCM read return, joins two bank words into the 64-bit fetch data
// Start bank goes to the low half, its successor to the high half
//*********************************************************************

`timescale 1ns/1ps
`include "ccm_mem_params.svh"

module iccm_rd_return
   import ccm_mem_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        rden,
   input  logic [`CCM_BANK_BITS-1:0]   start_bank,
   input  bank_data_vec_t              bank_data,
   output iccm_rsp_t                   rsp
);

   logic [`CCM_BANK_BITS-1:0]  start_q;
   logic [`CCM_BANK_BITS-1:0]  next_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) start_q <= '0;
      else if (rden) start_q <= start_bank;
   end

   assign next_q = start_q + `CCM_BANK_BITS'(1);   // Modulo bank count

   assign rsp.rd_data = {bank_data[next_q], bank_data[start_q]};

endmodule

//--- rtl/ccm_mem_top.sv
//*********************************************************************
// Closely coupled memories, a four-bank DCCM and a four-bank ICCM
// Requests are taken every cycle, read data follows one clock later
//*********************************************************************

`timescale 1ns/1ps
`include "ccm_mem_params.svh"

module ccm_mem_top
   import ccm_mem_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  dccm_req_t  dccm_req,
   input  iccm_req_t  iccm_req,
   output dccm_rsp_t  dccm_rsp,
   output iccm_rsp_t  iccm_rsp
);

   localparam int BANK_DEPTH = 2 ** `CCM_INDEX_BITS;

   bank_cmd_vec_t               dccm_cmd;
   bank_cmd_vec_t               iccm_cmd;
   bank_data_vec_t              dccm_data;
   bank_data_vec_t              iccm_data;
   logic [`CCM_BANK_BITS-1:0]   dccm_rd_bank_lo;
   logic [`CCM_BANK_BITS-1:0]   dccm_rd_bank_hi;
   logic [`CCM_BANK_BITS-1:0]   iccm_start_bank;

   //******************************************************************
   // DCCM
   //******************************************************************
   dccm_bank_decode i_dccm_bank_decode (
      .req        (dccm_req),
      .bank_cmd   (dccm_cmd),
      .rd_bank_lo (dccm_rd_bank_lo),
      .rd_bank_hi (dccm_rd_bank_hi)
   );

   for (genvar b = 0; b < `CCM_NUM_BANKS; b++) begin : g_dccm_bank
      ccm_bank #(.DEPTH(BANK_DEPTH)) i_ccm_bank (
         .clk     (clk),
         .rst_n   (rst_n),
         .cmd     (dccm_cmd[b]),
         .rd_data (dccm_data[b])
      );
   end

   dccm_rd_return i_dccm_rd_return (
      .clk        (clk),
      .rst_n      (rst_n),
      .rden       (dccm_req.rden),
      .rd_bank_lo (dccm_rd_bank_lo),
      .rd_bank_hi (dccm_rd_bank_hi),
      .bank_data  (dccm_data),
      .rsp        (dccm_rsp)
   );

   //******************************************************************
   // ICCM
   //******************************************************************
   iccm_bank_decode i_iccm_bank_decode (
      .req        (iccm_req),
      .bank_cmd   (iccm_cmd),
      .start_bank (iccm_start_bank)
   );

   for (genvar b = 0; b < `CCM_NUM_BANKS; b++) begin : g_iccm_bank
      ccm_bank #(.DEPTH(BANK_DEPTH)) i_ccm_bank (
         .clk     (clk),
         .rst_n   (rst_n),
         .cmd     (iccm_cmd[b]),
         .rd_data (iccm_data[b])
      );
   end

   iccm_rd_return i_iccm_rd_return (
      .clk        (clk),
      .rst_n      (rst_n),
      .rden       (iccm_req.rden),
      .start_bank (iccm_start_bank),
      .bank_data  (iccm_data),
      .rsp        (iccm_rsp)
   );

endmodule

//--- verification/ccm_mem_tb.sv
//*********************************************************************
// Directed testbench for the DCCM and ICCM block
// Keeps a word model of each memory and checks responses one clock later
//*********************************************************************

`timescale 1ns/1ps
`include "ccm_mem_params.svh"

module ccm_mem_tb
   import ccm_mem_pkg::*;
;

   localparam int TIMEOUT_CYCLES = 20000;

   logic        clk = 1'b0;
   logic        rst_n;
   dccm_req_t   dccm_req;
   iccm_req_t   iccm_req;
   dccm_rsp_t   dccm_rsp;
   iccm_rsp_t   iccm_rsp;

   logic [31:0] dmem [256];   // DCCM model, one entry per word
   logic [31:0] imem [256];   // ICCM model, one entry per word
   logic [63:0] dexp_now;
   logic [63:0] dexp_next;
   logic [63:0] iexp_now;
   logic [63:0] iexp_next;
   int          err_count;
   int          test_count;
   int          test_errs_start;

   always #20 clk = ~clk;

   ccm_mem_top i_ccm_mem_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .dccm_req (dccm_req),
      .iccm_req (iccm_req),
      .dccm_rsp (dccm_rsp),
      .iccm_rsp (iccm_rsp)
   );

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         $display("Mismatch %s expected 0x%h actual 0x%h", name, exp, act);
         err_count++;
      end
   endtask

   //******************************************************************
   // Drivers with model update
   //******************************************************************
   task automatic dccm_drive(input logic wren, input logic rden,
                             input logic [9:0] wlo, input logic [9:0] whi,
                             input logic [9:0] rlo, input logic [9:0] rhi,
                             input logic [31:0] dlo, input logic [31:0] dhi);
      dccm_req_t   r;
      logic [31:0] lo_word;
      logic [31:0] hi_word;
      r.wren = wren;
      r.rden = rden;
      r.wr_addr_lo = wlo;
      r.wr_addr_hi = whi;
      r.rd_addr_lo = rlo;
      r.rd_addr_hi = rhi;
      r.wr_data_lo = dlo;
      r.wr_data_hi = dhi;
      @(posedge clk);
      dccm_req <= r;
      dexp_now = dexp_next;   // Request before this one is now visible
      if (rden) begin
         lo_word = dmem[rlo[9:2]];
         hi_word = (rlo[3:2] == rhi[3:2]) ? lo_word : dmem[rhi[9:2]];
         dexp_next = {lo_word, hi_word};   // Old data even on a same-row write
      end
      if (wren) begin
         dmem[wlo[9:2]] = dlo;
         if (wlo[3:2] != whi[3:2]) dmem[whi[9:2]] = dhi;
      end
   endtask

   task automatic iccm_drive(input logic wren, input logic rden, input logic [7:0] w,
                             input logic [2:0] size, input logic [63:0] data);
      iccm_req_t r;
      r.wren    = wren;
      r.rden    = rden;
      r.rw_addr = w;
      r.wr_size = size;
      r.wr_data = data;
      @(posedge clk);
      iccm_req <= r;
      iexp_now = iexp_next;
      if (rden) iexp_next = {imem[w + 8'd1], imem[w]};   // Next word may wrap to the next row
      if (wren) begin
         imem[w] = data[31:0];
         if (size == 3'd3) imem[w + 8'd1] = data[63:32];
      end
   endtask

   task automatic dccm_check();
      @(negedge clk);
      check_value("dccm_rsp.rd_data_lo", {32'h0, dexp_now[63:32]}, {32'h0, dccm_rsp.rd_data_lo});
      check_value("dccm_rsp.rd_data_hi", {32'h0, dexp_now[31:0]}, {32'h0, dccm_rsp.rd_data_hi});
   endtask

   task automatic iccm_check();
      @(negedge clk);
      check_value("iccm_rsp.rd_data", iexp_now, iccm_rsp.rd_data);
   endtask

   task automatic finish_test(input string name);
      test_count++;
      $display("%s done, %0d errors", name, err_count - test_errs_start);
      test_errs_start = err_count;
   endtask

   //******************************************************************
   // Directed tests
   //******************************************************************
   task automatic test_reset_values();
      @(negedge clk);
      check_value("dccm_rsp", 64'h0, dccm_rsp);
      check_value("iccm_rsp", 64'h0, iccm_rsp.rd_data);
      finish_test("reset_values");
   endtask

   task automatic test_dccm_aligned();
      logic [9:0] a;
      for (int b = 0; b < 4; b++) begin
         a = 10'h40 + 10'(b * 4);
         dccm_drive(1'b1, 1'b0, a, a, 10'h0, 10'h0, $urandom, $urandom);
      end
      for (int b = 0; b < 4; b++) begin
         a = 10'h40 + 10'(b * 4);
         dccm_drive(1'b0, 1'b1, 10'h0, 10'h0, a, a, 32'h0, 32'h0);
         dccm_drive(1'b0, 1'b0, 10'h0, 10'h0, 10'h0, 10'h0, 32'h0, 32'h0);
         dccm_check();
      end
      finish_test("dccm_aligned");
   endtask

   task automatic test_dccm_misaligned();
      // Lo in bank 3 of row 2, hi in bank 0 of row 3
      dccm_drive(1'b1, 1'b0, 10'h02C, 10'h030, 10'h0, 10'h0, 32'h1111_2222, 32'h3333_4444);
      dccm_drive(1'b0, 1'b1, 10'h0, 10'h0, 10'h02C, 10'h030, 32'h0, 32'h0);
      dccm_drive(1'b0, 1'b0, 10'h0, 10'h0, 10'h0, 10'h0, 32'h0, 32'h0);
      dccm_check();
      // Same bank on both sides, hi word must stay
      dccm_drive(1'b1, 1'b0, 10'h090, 10'h090, 10'h0, 10'h0, 32'hAAAA_0090, 32'h0);
      dccm_drive(1'b1, 1'b0, 10'h080, 10'h090, 10'h0, 10'h0, 32'h5555_0080, 32'hDEAD_BEEF);
      dccm_drive(1'b0, 1'b1, 10'h0, 10'h0, 10'h080, 10'h090, 32'h0, 32'h0);
      dccm_drive(1'b0, 1'b1, 10'h0, 10'h0, 10'h090, 10'h02C, 32'h0, 32'h0);
      dccm_check();
      dccm_drive(1'b0, 1'b0, 10'h0, 10'h0, 10'h0, 10'h0, 32'h0, 32'h0);
      dccm_check();
      finish_test("dccm_misaligned");
   endtask

   task automatic test_iccm_double();
      iccm_drive(1'b1, 1'b0, 8'h05, 3'd3, 64'h0102_0304_0506_0708);   // Start bank 1
      iccm_drive(1'b1, 1'b0, 8'h07, 3'd3, 64'h8877_6655_4433_2211);   // Bank 3, wraps
      iccm_drive(1'b0, 1'b1, 8'h05, 3'd0, 64'h0);
      iccm_drive(1'b0, 1'b1, 8'h07, 3'd0, 64'h0);
      iccm_check();
      iccm_drive(1'b0, 1'b0, 8'h00, 3'd0, 64'h0);
      iccm_check();
      finish_test("iccm_double");
   endtask

   task automatic test_iccm_word();
      iccm_drive(1'b1, 1'b0, 8'h05, 3'd2, 64'hFFFF_FFFF_CAFE_F00D);
      iccm_drive(1'b0, 1'b1, 8'h05, 3'd0, 64'h0);
      iccm_drive(1'b0, 1'b0, 8'h00, 3'd0, 64'h0);
      iccm_check();
      check_value("iccm_rsp.rd_data", 64'h0102_0304_CAFE_F00D, iccm_rsp.rd_data);
      finish_test("iccm_word");
   endtask

   task automatic test_dccm_random();
      logic [9:0] lo;
      logic [9:0] hi;
      int         mode;
      // Fill the whole DCCM so every read has a known value
      for (int w = 0; w < 256; w += 2) begin
         dccm_drive(1'b1, 1'b0, 10'(w * 4), 10'(w * 4 + 4), 10'h0, 10'h0, $urandom, $urandom);
      end
      for (int i = 0; i < 200; i++) begin
         mode = $urandom % 4;
         lo   = 10'($urandom) & 10'h3FC;
         hi   = $urandom % 2 ? lo + 10'd4 : 10'($urandom) & 10'h3FC;
         case (mode)
            0: dccm_drive(1'b0, 1'b1, 10'h0, 10'h0, lo, hi, 32'h0, 32'h0);
            1: dccm_drive(1'b1, 1'b0, lo, hi, 10'h0, 10'h0, $urandom, $urandom);
            2: dccm_drive(1'b1, 1'b1, lo, hi, lo, hi, $urandom, $urandom);   // Same rows
            default: dccm_drive(1'b0, 1'b0, 10'h0, 10'h0, 10'h0, 10'h0, 32'h0, 32'h0);
         endcase
         dccm_check();
      end
      dccm_drive(1'b0, 1'b0, 10'h0, 10'h0, 10'h0, 10'h0, 32'h0, 32'h0);
      dccm_check();
      finish_test("dccm_random");
   endtask

   //******************************************************************
   // Sequence and watchdog
   //******************************************************************
   initial begin
      rst_n = 1'b0;
      dccm_req = '0;
      iccm_req = '0;
      dexp_now = '0;
      dexp_next = '0;
      iexp_now = '0;
      iexp_next = '0;
      err_count = 0;
      test_count = 0;
      test_errs_start = 0;
      void'($urandom(67998));
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      test_reset_values();
      test_dccm_aligned();
      test_dccm_misaligned();
      test_iccm_double();
      test_iccm_word();
      test_dccm_random();
      $display("Tests run %0d, errors %0d", test_count, err_count);
      if (err_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- ccm_mem.f
+incdir+rtl
rtl/ccm_mem_pkg.sv
rtl/ccm_bank.sv
rtl/dccm_bank_decode.sv
rtl/iccm_bank_decode.sv
rtl/dccm_rd_return.sv
rtl/iccm_rd_return.sv
rtl/ccm_mem_top.sv
verification/ccm_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the CCM testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f ccm_mem.f --top-module ccm_mem_tb -o ccm_mem_sim \
   || { echo "Verilator build failed"; exit 1; }

output=$(./obj_dir/ccm_mem_sim)
echo "$output"

echo "$output" | grep -qF '** PASS **' && exit 0 || exit 1
